//--- src/icache_pkg.sv
// Geometry, types and small helpers shared by every part of the instruction cache
// Direct mapped with a single way; all sizes are fixed here and modules have no parameters
// NR_FETCH_PORTS is expected to be a power of two for the round-robin pointer wrap
package icache_pkg;

  localparam int unsigned NR_FETCH_PORTS = 2;
  localparam int unsigned FETCH_AW = 32;
  localparam int unsigned FETCH_DW = 32;
  localparam int unsigned LINE_WIDTH = 128;
  localparam int unsigned LINE_COUNT = 16;
  localparam int unsigned FETCH_ALIGN = $clog2(FETCH_DW / 8);
  localparam int unsigned LINE_ALIGN = $clog2(LINE_WIDTH / 8);
  localparam int unsigned COUNT_ALIGN = $clog2(LINE_COUNT);
  localparam int unsigned TAG_WIDTH = FETCH_AW - LINE_ALIGN - COUNT_ALIGN;
  localparam int unsigned PORT_SEL_W = $clog2(NR_FETCH_PORTS);

  typedef logic [FETCH_AW-1:0] addr_t;
  typedef logic [FETCH_DW-1:0] word_t;
  typedef logic [LINE_WIDTH-1:0] line_t;
  typedef logic [TAG_WIDTH-1:0] tag_t;
  typedef logic [COUNT_ALIGN-1:0] index_t;
  typedef logic [NR_FETCH_PORTS-1:0] port_id_t;
  typedef logic [PORT_SEL_W-1:0] port_sel_t;

  typedef enum logic [1:0] {Idle, RequestData, WaitResponse, PresentResponse} bypass_state_e;

  function automatic index_t addr_index(addr_t addr);
    return addr[LINE_ALIGN +: COUNT_ALIGN];
  endfunction

  function automatic tag_t addr_tag(addr_t addr);
    return addr[FETCH_AW-1 -: TAG_WIDTH];
  endfunction

  // Address of the first byte of the line that holds addr
  function automatic addr_t line_base(addr_t addr);
    return {addr[FETCH_AW-1:LINE_ALIGN], {LINE_ALIGN{1'b0}}};
  endfunction

  function automatic word_t select_word(line_t line, addr_t addr);
    return line[addr[LINE_ALIGN-1:FETCH_ALIGN] * FETCH_DW +: FETCH_DW];
  endfunction

  // First requesting port at or after start, wrapping around
  function automatic port_sel_t rr_pick(logic [NR_FETCH_PORTS-1:0] req, port_sel_t start);
    port_sel_t idx;
    port_sel_t sel;
    sel = start;
    for (int k = NR_FETCH_PORTS - 1; k >= 0; k--) begin
      idx = port_sel_t'((start + k) % NR_FETCH_PORTS);
      if (req[idx]) sel = idx;
    end
    return sel;
  endfunction

endpackage

//--- src/icache_if.sv
// Internal channels of the instruction cache
// Valid and payload stay stable until ready; fetch_rsp_if and line_write_if have no ready
`timescale 1ns/10ps

interface lookup_req_if;
  import icache_pkg::*;
  logic valid;
  logic ready;
  addr_t addr;
  port_id_t id;
  modport master (output valid, output addr, output id, input ready);
  modport slave (input valid, input addr, input id, output ready);
endinterface

interface lookup_out_if;
  import icache_pkg::*;
  logic valid;
  logic ready;
  addr_t addr;
  port_id_t id;
  logic hit;
  line_t data;
  logic error;
  modport master (output valid, output addr, output id, output hit, output data, output error,
                  input ready);
  modport slave (input valid, input addr, input id, input hit, input data, input error,
                 output ready);
endinterface

interface fetch_rsp_if;
  import icache_pkg::*;
  logic valid;
  port_id_t id;
  word_t data;
  logic error;
  modport master (output valid, output id, output data, output error);
  modport slave (input valid, input id, input data, input error);
endinterface

interface line_write_if;
  import icache_pkg::*;
  logic valid;
  index_t index;
  tag_t tag;
  line_t data;
  logic error;
  modport master (output valid, output index, output tag, output data, output error);
  modport slave (input valid, input index, input tag, input data, input error);
endinterface

interface refill_if;
  import icache_pkg::*;
  logic req_valid;
  logic req_ready;
  addr_t req_addr;
  logic rsp_valid;
  logic rsp_ready;
  line_t rsp_data;
  logic rsp_error;
  modport master (output req_valid, output req_addr, output rsp_ready,
                  input req_ready, input rsp_valid, input rsp_data, input rsp_error);
  modport slave (input req_valid, input req_addr, input rsp_ready,
                 output req_ready, output rsp_valid, output rsp_data, output rsp_error);
endinterface

//--- src/icache_fetch_arb.sv
// Round-robin arbiter of the cacheable fetch ports into the lookup
// Each port holds its request until its ready pulse and is granted only once per request
`timescale 1ns/10ps

module icache_fetch_arb (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic              [icache_pkg::NR_FETCH_PORTS-1:0] fetch_valid_i,
  input  icache_pkg::addr_t [icache_pkg::NR_FETCH_PORTS-1:0] fetch_addr_i,
  output logic              [icache_pkg::NR_FETCH_PORTS-1:0] fetch_ready_o,
  output icache_pkg::word_t [icache_pkg::NR_FETCH_PORTS-1:0] fetch_data_o,
  output logic              [icache_pkg::NR_FETCH_PORTS-1:0] fetch_error_o,
  lookup_req_if.master                                   lookup,
  fetch_rsp_if.slave                                     rsp
);
  import icache_pkg::*;

  logic [NR_FETCH_PORTS-1:0] granted_q;
  logic [NR_FETCH_PORTS-1:0] eligible;
  port_sel_t rr_q;
  port_sel_t held_q;
  logic hold_q;
  port_sel_t pick;
  port_id_t pick_id;
  logic accept;

  assign eligible = fetch_valid_i & ~granted_q;
  // A stalled offer keeps its port so the lookup sees a stable request
  assign pick = hold_q ? held_q : rr_pick(eligible, rr_q);
  assign pick_id = port_id_t'(1) << pick;

  assign lookup.valid = hold_q || (|eligible);
  assign lookup.addr = fetch_addr_i[pick];
  assign lookup.id = pick_id;
  assign accept = lookup.valid && lookup.ready;

  assign fetch_ready_o = {NR_FETCH_PORTS{rsp.valid}} & rsp.id;
  assign fetch_data_o = {NR_FETCH_PORTS{rsp.data}};
  assign fetch_error_o = {NR_FETCH_PORTS{rsp.error}};

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      granted_q <= '0;
      rr_q <= '0;
      held_q <= '0;
      hold_q <= 1'b0;
    end else begin
      granted_q <= (granted_q | (accept ? pick_id : '0)) & ~fetch_ready_o;
      if (accept) begin
        rr_q <= port_sel_t'((pick + 1) % NR_FETCH_PORTS);
        hold_q <= 1'b0;
      end else if (lookup.valid) begin
        hold_q <= 1'b1;
        held_q <= pick;
      end
    end
  end

endmodule

//--- src/icache_lookup.sv
// Direct-mapped L1 arrays with a single registered read stage
// The tag compare happens on the output stage; a line write takes the cycle from new lookups
// A flush waits until the output stage is empty and no write is active
`timescale 1ns/10ps

module icache_lookup (
  input  logic         clk_i,
  input  logic         reset_i,
  lookup_req_if.slave  req,
  lookup_out_if.master out,
  line_write_if.slave  write,
  input  logic         flush_valid_i,
  output logic         flush_ready_o
);
  import icache_pkg::*;

  tag_t tag_mem [LINE_COUNT];
  line_t data_mem [LINE_COUNT];
  logic error_mem [LINE_COUNT];
  logic [LINE_COUNT-1:0] valid_q;

  logic out_valid_q;
  addr_t out_addr_q;
  port_id_t out_id_q;
  tag_t out_tag_q;
  line_t out_data_q;
  logic out_error_q;
  logic out_line_valid_q;
  index_t req_index;
  logic accept;

  assign req_index = addr_index(req.addr);
  // A pending flush blocks new lookups so the output stage can drain
  assign req.ready = !write.valid && !flush_valid_i && (!out_valid_q || out.ready);
  assign accept = req.valid && req.ready;
  assign flush_ready_o = flush_valid_i && !write.valid && !out_valid_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_q <= '0;
      out_valid_q <= 1'b0;
    end else begin
      if (flush_ready_o) begin
        valid_q <= '0;
      end else if (write.valid) begin
        valid_q[write.index] <= 1'b1;
      end
      if (accept) begin
        out_valid_q <= 1'b1;
      end else if (out.ready) begin
        out_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (write.valid) begin
      tag_mem[write.index] <= write.tag;
      data_mem[write.index] <= write.data;
      error_mem[write.index] <= write.error;
    end
    if (accept) begin
      out_addr_q <= req.addr;
      out_id_q <= req.id;
      out_tag_q <= tag_mem[req_index];
      out_data_q <= data_mem[req_index];
      out_error_q <= error_mem[req_index];
      out_line_valid_q <= valid_q[req_index];
    end
  end

  assign out.valid = out_valid_q;
  assign out.addr = out_addr_q;
  assign out.id = out_id_q;
  assign out.hit = out_line_valid_q && (out_tag_q == addr_tag(out_addr_q));
  assign out.data = out_data_q;
  assign out.error = out_error_q;

endmodule

//--- src/icache_handler.sv
// Miss handler behind the lookup stage
// Hits answer one cycle after they are consumed; only one miss is outstanding at a time
// A missed lookup result is held in the lookup stage until its line returns
`timescale 1ns/10ps

module icache_handler (
  input  logic         clk_i,
  input  logic         reset_i,
  lookup_out_if.slave  in,
  fetch_rsp_if.master  rsp,
  line_write_if.master write,
  refill_if.master     refill
);
  import icache_pkg::*;

  logic pending_q;
  logic req_valid_q;
  addr_t miss_addr_q;
  port_id_t miss_id_q;
  logic hit_valid_q;
  port_id_t hit_id_q;
  word_t hit_data_q;
  logic hit_error_q;
  logic take_hit;
  logic take_miss;
  logic refill_done;

  assign take_hit = in.valid && in.hit && !pending_q;
  assign take_miss = in.valid && !in.hit && !pending_q;
  assign refill_done = pending_q && refill.rsp_valid;
  assign in.ready = take_hit || refill_done;

  assign refill.req_valid = req_valid_q;
  assign refill.req_addr = line_base(miss_addr_q);
  assign refill.rsp_ready = pending_q;

  // The refilled line goes into the cache in the cycle it is returned to the port
  assign write.valid = refill_done;
  assign write.index = addr_index(miss_addr_q);
  assign write.tag = addr_tag(miss_addr_q);
  assign write.data = refill.rsp_data;
  assign write.error = refill.rsp_error;

  assign rsp.valid = hit_valid_q || refill_done;
  assign rsp.id = hit_valid_q ? hit_id_q : miss_id_q;
  assign rsp.data = hit_valid_q ? hit_data_q : select_word(refill.rsp_data, miss_addr_q);
  assign rsp.error = hit_valid_q ? hit_error_q : refill.rsp_error;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= 1'b0;
      req_valid_q <= 1'b0;
      hit_valid_q <= 1'b0;
    end else begin
      hit_valid_q <= take_hit;
      if (take_miss) begin
        pending_q <= 1'b1;
        req_valid_q <= 1'b1;
      end else begin
        if (refill.req_ready) begin
          req_valid_q <= 1'b0;
        end
        if (refill_done) begin
          pending_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take_hit) begin
      hit_id_q <= in.id;
      hit_data_q <= select_word(in.data, in.addr);
      hit_error_q <= in.error;
    end
    if (take_miss) begin
      miss_addr_q <= in.addr;
      miss_id_q <= in.id;
    end
  end

endmodule

//--- src/icache_bypass.sv
// Uncacheable fetch path, one state machine per port
// Ports take turns for the single outstanding line request and never fill the cache
// The word is presented for one cycle, one cycle after the line response
`timescale 1ns/10ps

module icache_bypass (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic              [icache_pkg::NR_FETCH_PORTS-1:0] in_valid_i,
  input  icache_pkg::addr_t [icache_pkg::NR_FETCH_PORTS-1:0] in_addr_i,
  output logic              [icache_pkg::NR_FETCH_PORTS-1:0] in_ready_o,
  output icache_pkg::word_t [icache_pkg::NR_FETCH_PORTS-1:0] in_data_o,
  output logic              [icache_pkg::NR_FETCH_PORTS-1:0] in_error_o,
  refill_if.master                                       refill
);
  import icache_pkg::*;

  bypass_state_e state_q [NR_FETCH_PORTS];
  bypass_state_e state_d [NR_FETCH_PORTS];
  logic [NR_FETCH_PORTS-1:0] waiting;
  logic busy_q;
  logic req_valid_q;
  addr_t req_addr_q;
  port_sel_t owner_q;
  port_sel_t rr_q;
  port_sel_t pick;
  logic issue;
  logic rsp_fire;

  for (genvar i = 0; i < NR_FETCH_PORTS; i++) begin : gen_waiting
    assign waiting[i] = (state_q[i] == RequestData);
  end

  // A new line request is latched only while nothing is outstanding
  assign issue = !busy_q && (|waiting);
  assign pick = rr_pick(waiting, rr_q);
  assign rsp_fire = refill.rsp_valid && refill.rsp_ready;

  assign refill.req_valid = req_valid_q;
  assign refill.req_addr = req_addr_q;
  assign refill.rsp_ready = busy_q && !req_valid_q;

  always_comb begin
    for (int i = 0; i < NR_FETCH_PORTS; i++) begin
      state_d[i] = state_q[i];
      in_ready_o[i] = 1'b0;
      unique case (state_q[i])
        Idle: if (in_valid_i[i]) state_d[i] = RequestData;
        RequestData: if (issue && pick == port_sel_t'(i)) state_d[i] = WaitResponse;
        WaitResponse: if (rsp_fire && owner_q == port_sel_t'(i)) state_d[i] = PresentResponse;
        PresentResponse: begin
          state_d[i] = Idle;
          in_ready_o[i] = 1'b1;
        end
        default: state_d[i] = Idle;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= '{default: Idle};
      busy_q <= 1'b0;
      req_valid_q <= 1'b0;
      owner_q <= '0;
      rr_q <= '0;
    end else begin
      state_q <= state_d;
      if (issue) begin
        busy_q <= 1'b1;
        req_valid_q <= 1'b1;
        owner_q <= pick;
        rr_q <= port_sel_t'((pick + 1) % NR_FETCH_PORTS);
      end else begin
        if (refill.req_ready) begin
          req_valid_q <= 1'b0;
        end
        if (rsp_fire) begin
          busy_q <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue) begin
      req_addr_q <= line_base(in_addr_i[pick]);
    end
    for (int i = 0; i < NR_FETCH_PORTS; i++) begin
      if (rsp_fire && owner_q == port_sel_t'(i)) begin
        in_data_o[i] <= select_word(refill.rsp_data, in_addr_i[i]);
        in_error_o[i] <= refill.rsp_error;
      end
    end
  end

endmodule

//--- src/icache_refill.sv
// Shares the memory port between the miss handler and the bypass path
// One request is outstanding at a time; the response goes back to the source that asked
// A request stalled by mem_req_ready_i keeps its source until it is accepted
`timescale 1ns/10ps

module icache_refill (
  input  logic              clk_i,
  input  logic              reset_i,
  refill_if.slave           handler,
  refill_if.slave           bypass,
  output logic              mem_req_valid_o,
  input  logic              mem_req_ready_i,
  output icache_pkg::addr_t mem_req_addr_o,
  input  logic              mem_rsp_valid_i,
  output logic              mem_rsp_ready_o,
  input  icache_pkg::line_t mem_rsp_data_i,
  input  logic              mem_rsp_error_i
);

  logic busy_q;
  logic hold_q;
  logic src_q;
  logic last_q;
  logic pick_bypass;
  logic req_fire;

  // The bypass path wins when it is alone or when the handler was served last
  assign pick_bypass = hold_q ? src_q
                              : bypass.req_valid && (!handler.req_valid || !last_q);
  assign mem_req_valid_o = !busy_q && (pick_bypass ? bypass.req_valid : handler.req_valid);
  assign mem_req_addr_o = pick_bypass ? bypass.req_addr : handler.req_addr;
  assign req_fire = mem_req_valid_o && mem_req_ready_i;

  assign handler.req_ready = !busy_q && !pick_bypass && mem_req_ready_i;
  assign bypass.req_ready = !busy_q && pick_bypass && mem_req_ready_i;

  assign handler.rsp_valid = busy_q && !src_q && mem_rsp_valid_i;
  assign bypass.rsp_valid = busy_q && src_q && mem_rsp_valid_i;
  assign mem_rsp_ready_o = busy_q && (src_q ? bypass.rsp_ready : handler.rsp_ready);
  assign handler.rsp_data = mem_rsp_data_i;
  assign handler.rsp_error = mem_rsp_error_i;
  assign bypass.rsp_data = mem_rsp_data_i;
  assign bypass.rsp_error = mem_rsp_error_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      busy_q <= 1'b0;
      hold_q <= 1'b0;
      src_q <= 1'b0;
      last_q <= 1'b0;
    end else begin
      if (req_fire) begin
        busy_q <= 1'b1;
        hold_q <= 1'b0;
        src_q <= pick_bypass;
        last_q <= pick_bypass;
      end else if (mem_req_valid_o) begin
        hold_q <= 1'b1;
        src_q <= pick_bypass;
      end
      if (mem_rsp_valid_i && mem_rsp_ready_o) begin
        busy_q <= 1'b0;
      end
    end
  end

endmodule

//--- src/icache.sv
// Two-port instruction cache with an uncacheable bypass path
// Fetch requests are held until the one-cycle inst_ready_o pulse
// The memory port carries whole 128-bit lines with one request outstanding
`timescale 1ns/10ps

module icache (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic              [icache_pkg::NR_FETCH_PORTS-1:0] inst_valid_i,
  input  icache_pkg::addr_t [icache_pkg::NR_FETCH_PORTS-1:0] inst_addr_i,
  input  logic              [icache_pkg::NR_FETCH_PORTS-1:0] inst_cacheable_i,
  output logic              [icache_pkg::NR_FETCH_PORTS-1:0] inst_ready_o,
  output icache_pkg::word_t [icache_pkg::NR_FETCH_PORTS-1:0] inst_data_o,
  output logic              [icache_pkg::NR_FETCH_PORTS-1:0] inst_error_o,
  input  logic                                           flush_valid_i,
  output logic                                           flush_ready_o,
  output logic                                           mem_req_valid_o,
  input  logic                                           mem_req_ready_i,
  output icache_pkg::addr_t                              mem_req_addr_o,
  input  logic                                           mem_rsp_valid_i,
  output logic                                           mem_rsp_ready_o,
  input  icache_pkg::line_t                              mem_rsp_data_i,
  input  logic                                           mem_rsp_error_i
);
  import icache_pkg::*;

  logic [NR_FETCH_PORTS-1:0] cache_valid;
  logic [NR_FETCH_PORTS-1:0] cache_ready;
  logic [NR_FETCH_PORTS-1:0] cache_error;
  word_t [NR_FETCH_PORTS-1:0] cache_data;
  logic [NR_FETCH_PORTS-1:0] bypass_valid;
  logic [NR_FETCH_PORTS-1:0] bypass_ready;
  logic [NR_FETCH_PORTS-1:0] bypass_error;
  word_t [NR_FETCH_PORTS-1:0] bypass_data;

  lookup_req_if lookup_req ();
  lookup_out_if lookup_out ();
  fetch_rsp_if fetch_rsp ();
  line_write_if line_write ();
  refill_if handler_refill ();
  refill_if bypass_refill ();

  // Each port goes either through the cache or around it
  assign cache_valid = inst_valid_i & inst_cacheable_i;
  assign bypass_valid = inst_valid_i & ~inst_cacheable_i;
  assign inst_ready_o = (cache_ready & inst_cacheable_i) | (bypass_ready & ~inst_cacheable_i);
  assign inst_error_o = (cache_error & inst_cacheable_i) | (bypass_error & ~inst_cacheable_i);

  for (genvar i = 0; i < NR_FETCH_PORTS; i++) begin : gen_data_mux
    assign inst_data_o[i] = inst_cacheable_i[i] ? cache_data[i] : bypass_data[i];
  end

  icache_fetch_arb u_fetch_arb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .fetch_valid_i (cache_valid),
    .fetch_addr_i  (inst_addr_i),
    .fetch_ready_o (cache_ready),
    .fetch_data_o  (cache_data),
    .fetch_error_o (cache_error),
    .lookup        (lookup_req),
    .rsp           (fetch_rsp)
  );

  icache_lookup u_lookup (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req           (lookup_req),
    .out           (lookup_out),
    .write         (line_write),
    .flush_valid_i (flush_valid_i),
    .flush_ready_o (flush_ready_o)
  );

  icache_handler u_handler (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .in      (lookup_out),
    .rsp     (fetch_rsp),
    .write   (line_write),
    .refill  (handler_refill)
  );

  icache_bypass u_bypass (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .in_valid_i (bypass_valid),
    .in_addr_i  (inst_addr_i),
    .in_ready_o (bypass_ready),
    .in_data_o  (bypass_data),
    .in_error_o (bypass_error),
    .refill     (bypass_refill)
  );

  icache_refill u_refill (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .handler         (handler_refill),
    .bypass          (bypass_refill),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_req_addr_o  (mem_req_addr_o),
    .mem_rsp_valid_i (mem_rsp_valid_i),
    .mem_rsp_ready_o (mem_rsp_ready_o),
    .mem_rsp_data_i  (mem_rsp_data_i),
    .mem_rsp_error_i (mem_rsp_error_i)
  );

endmodule

//--- testbench/tb_clock_gen.sv
// Free-running 10 ns clock and a synchronous reset held for the first 5 rising edges
`timescale 1ns/10ps

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

//--- testbench/icache_tb.sv
// Testbench for the two-port instruction cache
// The memory model answers one line request at a time with random back-pressure and latency
// Every word of memory is its own byte address XOR WORD_KEY; bit 31 of the address flags an error
`timescale 1ns/10ps

module icache_tb;
  import icache_pkg::*;

  localparam int NUM_TESTS = 16;
  localparam int TIMEOUT_CYCLES = NUM_TESTS * 40;
  localparam logic [31:0] WORD_KEY = 32'hA5C3_0F96;
  localparam logic [31:0] LCG_SEED = 32'd99546;

  logic clk;
  logic reset;
  logic [NR_FETCH_PORTS-1:0] inst_valid = '0;
  addr_t [NR_FETCH_PORTS-1:0] inst_addr = '0;
  logic [NR_FETCH_PORTS-1:0] inst_cacheable = '0;
  logic [NR_FETCH_PORTS-1:0] inst_ready;
  word_t [NR_FETCH_PORTS-1:0] inst_data;
  logic [NR_FETCH_PORTS-1:0] inst_error;
  logic flush_valid = 1'b0;
  logic flush_ready;
  logic mem_req_valid;
  logic mem_req_ready = 1'b0;
  addr_t mem_req_addr;
  logic mem_rsp_valid = 1'b0;
  logic mem_rsp_ready;
  line_t mem_rsp_data = '0;
  logic mem_rsp_error = 1'b0;

  // Memory model state
  logic [31:0] rng_q = LCG_SEED;
  logic mem_busy = 1'b0;
  addr_t mem_addr_q = '0;
  logic [2:0] delay_q = '0;
  int req_count = 0;
  int cycle_count = 0;

  // Stimulus table
  string t_name [NUM_TESTS];
  int t_port [NUM_TESTS];
  logic [31:0] t_addr [NUM_TESTS][NR_FETCH_PORTS];
  logic t_cacheable [NUM_TESTS];
  logic t_flush [NUM_TESTS];
  logic t_dual [NUM_TESTS];
  logic [31:0] t_exp_data [NUM_TESTS][NR_FETCH_PORTS];
  logic t_exp_error [NUM_TESTS][NR_FETCH_PORTS];
  int t_exp_reqs [NUM_TESTS];
  int n_entries = 0;

  tb_clock_gen u_clock_gen (
    .clk_o   (clk),
    .reset_o (reset)
  );

  icache dut0 (
    .clk_i            (clk),
    .reset_i          (reset),
    .inst_valid_i     (inst_valid),
    .inst_addr_i      (inst_addr),
    .inst_cacheable_i (inst_cacheable),
    .inst_ready_o     (inst_ready),
    .inst_data_o      (inst_data),
    .inst_error_o     (inst_error),
    .flush_valid_i    (flush_valid),
    .flush_ready_o    (flush_ready),
    .mem_req_valid_o  (mem_req_valid),
    .mem_req_ready_i  (mem_req_ready),
    .mem_req_addr_o   (mem_req_addr),
    .mem_rsp_valid_i  (mem_rsp_valid),
    .mem_rsp_ready_o  (mem_rsp_ready),
    .mem_rsp_data_i   (mem_rsp_data),
    .mem_rsp_error_i  (mem_rsp_error)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1103515245 + 32'd12345;
  endfunction

  // Content of the memory word that holds byte address addr
  function automatic logic [31:0] pattern_word(input logic [31:0] addr);
    return {addr[31:2], 2'b00} ^ WORD_KEY;
  endfunction

  // Word w of a line sits at bits w*32 and holds byte address base + 4*w
  function automatic line_t pattern_line(input logic [31:0] base);
    line_t line;
    for (int w = 0; w < LINE_WIDTH / 32; w++) begin
      line[w*32 +: 32] = pattern_word(base + 32'(4 * w));
    end
    return line;
  endfunction

  // The model serves one request at a time under random back-pressure
  // and answers each after 1 to 8 cycles
  always @(posedge clk) begin
    rng_q <= lcg_next(rng_q);
    mem_req_ready <= (rng_q[17:16] != 2'b00);
    if (reset) begin
      mem_busy <= 1'b0;
      mem_rsp_valid <= 1'b0;
      delay_q <= '0;
    end else if (!mem_busy) begin
      if (mem_req_valid && mem_req_ready) begin
        check_value("memory model", "request address offset", 0,
                    32'(mem_req_addr[LINE_ALIGN-1:0]));
        mem_busy <= 1'b1;
        mem_addr_q <= mem_req_addr;
        delay_q <= rng_q[26:24];
        req_count <= req_count + 1;
      end
    end else if (!mem_rsp_valid) begin
      if (delay_q == 3'd0) begin
        mem_rsp_valid <= 1'b1;
        mem_rsp_data <= pattern_line(mem_addr_q);
        mem_rsp_error <= mem_addr_q[31];
      end else begin
        delay_q <= delay_q - 3'd1;
      end
    end else if (mem_rsp_ready) begin
      mem_rsp_valid <= 1'b0;
      mem_busy <= 1'b0;
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Regression failed");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  task automatic check_value(input string test_name, input string field,
                             input logic [31:0] expected, input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Error: test %s, %s: expected %h, actual %h", test_name, field, expected,
               actual);
      $display("Regression failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // In a dual entry port takes addr and the other port takes addr_b
  task automatic add_entry(input string name, input int port, input logic [31:0] addr,
                           input logic cacheable, input logic flush, input logic dual,
                           input logic [31:0] addr_b, input int exp_reqs);
    t_name[n_entries] = name;
    t_port[n_entries] = port;
    t_addr[n_entries][port] = addr;
    t_addr[n_entries][1-port] = addr_b;
    t_cacheable[n_entries] = cacheable;
    t_flush[n_entries] = flush;
    t_dual[n_entries] = dual;
    for (int p = 0; p < NR_FETCH_PORTS; p++) begin
      t_exp_data[n_entries][p] = pattern_word(t_addr[n_entries][p]);
      t_exp_error[n_entries][p] = t_addr[n_entries][p][31];
    end
    t_exp_reqs[n_entries] = exp_reqs;
    n_entries++;
  endtask

  // Columns are name, port, address, cacheable, flush, dual, second address, new requests
  // Lines sit at distinct indices unless a test aims at an eviction
  task automatic fill_table();
    add_entry("miss_fill",              0, 32'h0000_1024, 1, 0, 0, 32'h0, 1);
    add_entry("hit_same_line",          1, 32'h0000_102C, 1, 0, 0, 32'h0, 0);
    add_entry("hit_other_port",         0, 32'h0000_1020, 1, 0, 0, 32'h0, 0);
    add_entry("bypass_first",           1, 32'h0000_2038, 0, 0, 0, 32'h0, 1);
    add_entry("bypass_again",           0, 32'h0000_2034, 0, 0, 0, 32'h0, 1);
    add_entry("cacheable_after_bypass", 0, 32'h0000_2038, 1, 0, 0, 32'h0, 1);
    add_entry("dual_miss",              0, 32'h0000_3044, 1, 0, 1, 32'h0000_4058, 2);
    add_entry("dual_line_hit",          1, 32'h0000_405C, 1, 0, 0, 32'h0, 0);
    add_entry("flush",                  0, 32'h0,         0, 1, 0, 32'h0, 0);
    add_entry("refetch_after_flush",    1, 32'h0000_1028, 1, 0, 0, 32'h0, 1);
    add_entry("error_cacheable",        0, 32'h8000_0060, 1, 0, 0, 32'h0, 1);
    add_entry("error_cached_hit",       1, 32'h8000_006C, 1, 0, 0, 32'h0, 0);
    add_entry("error_bypass",           1, 32'h8000_0074, 0, 0, 0, 32'h0, 1);
    add_entry("dual_bypass",            0, 32'h0000_5000, 0, 0, 1, 32'h0000_6004, 2);
    add_entry("index_conflict",         0, 32'h0001_1024, 1, 0, 0, 32'h0, 1);
    add_entry("evicted_line",           0, 32'h0000_1020, 1, 0, 0, 32'h0, 1);
  endtask

  task automatic run_entry(input int i);
    logic [NR_FETCH_PORTS-1:0] active;
    logic [NR_FETCH_PORTS-1:0] done;
    logic [31:0] got_data [NR_FETCH_PORTS];
    logic got_error [NR_FETCH_PORTS];
    int reqs_before;
    reqs_before = req_count;
    if (t_flush[i]) begin
      @(posedge clk);
      flush_valid <= 1'b1;
      @(posedge clk);
      while (!flush_ready) @(posedge clk);
      flush_valid <= 1'b0;
    end else begin
      active = t_dual[i] ? '1 : NR_FETCH_PORTS'(1 << t_port[i]);
      done = '0;
      @(posedge clk);
      for (int p = 0; p < NR_FETCH_PORTS; p++) begin
        if (active[p]) begin
          inst_valid[p] <= 1'b1;
          inst_addr[p] <= t_addr[i][p];
          inst_cacheable[p] <= t_cacheable[i];
        end
      end
      // Each port completes on its own ready pulse and drops valid on that edge
      while (done != active) begin
        @(posedge clk);
        for (int p = 0; p < NR_FETCH_PORTS; p++) begin
          if (!active[p] && inst_ready[p]) begin
            check_value(t_name[i], $sformatf("ready on idle port %0d", p), 0, 1);
          end
          if (active[p] && !done[p] && inst_ready[p]) begin
            got_data[p] = inst_data[p];
            got_error[p] = inst_error[p];
            done[p] = 1'b1;
            inst_valid[p] <= 1'b0;
          end
        end
      end
      for (int p = 0; p < NR_FETCH_PORTS; p++) begin
        if (active[p]) begin
          check_value(t_name[i], $sformatf("data port %0d", p), t_exp_data[i][p], got_data[p]);
          check_value(t_name[i], $sformatf("error port %0d", p), 32'(t_exp_error[i][p]),
                      32'(got_error[p]));
        end
      end
    end
    check_value(t_name[i], "memory requests", t_exp_reqs[i], req_count - reqs_before);
  endtask

  initial begin
    fill_table();
    @(posedge clk);
    while (reset !== 1'b0) @(posedge clk);
    check_value("reset", "inst_ready_o", 0, 32'(inst_ready));
    check_value("reset", "flush_ready_o", 0, 32'(flush_ready));
    check_value("reset", "mem_req_valid_o", 0, 32'(mem_req_valid));
    for (int i = 0; i < n_entries; i++) begin
      run_entry(i);
    end
    $display("Regression passed");
    $finish;
  end

endmodule

//--- verilog.f
src/icache_pkg.sv
src/icache_if.sv
src/icache_fetch_arb.sv
src/icache_lookup.sv
src/icache_handler.sv
src/icache_bypass.sv
src/icache_refill.sv
src/icache.sv
testbench/tb_clock_gen.sv
testbench/icache_tb.sv
